/* hw/rf_consts.svh */
// ----------------------------------------------------------
// Register file subsystem constants
// Array geometry, power sequencing delays and the APB
// register map of the power-gated 64x14 register file
// ----------------------------------------------------------
`ifndef RF_CONSTS_SVH
`define RF_CONSTS_SVH

// Array geometry
`define RF_DEPTH        64
`define RF_WIDTH        14
`define RF_ADDR_W       6

// Cycles from enable_b falling to the array acknowledge falling
`define RF_WAKE_CYCLES  4
// Flops in the IP reset staging chain of the wrapper
`define RF_RST_STAGES   2

// APB register map, byte addresses
`define RF_APB_ADDR_W   12
`define RF_REG_CTRL     12'h000
`define RF_REG_STATUS   12'h004
// Entry i lives at RF_ARRAY_BASE + 4*i
`define RF_ARRAY_BASE   12'h100

`endif

/* hw/rf_pkg.sv */
// ----------------------------------------------------------
// Register file subsystem types
// Vector types for entries and APB fields, and the
// power sequencer state encoding
// ----------------------------------------------------------
`include "rf_consts.svh"

package rf_pkg;

    // Entry index and entry payload of the array
    typedef logic [`RF_ADDR_W-1:0] rf_addr_t;
    typedef logic [`RF_WIDTH-1:0]  rf_data_t;

    // APB address and data word
    typedef logic [`RF_APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [31:0]               apb_data_t;

    // Power-gate sequencer states, in power-up order
    typedef enum logic [2:0] {
        PG_OFF,
        PG_WAKE,
        PG_RELEASE,
        PG_ON,
        PG_SLEEP
    } pg_state_t;

endpackage

/* hw/rf_ifs.sv */
// ----------------------------------------------------------
// Register file subsystem interfaces
// rf_port_if carries array read and write accesses,
// rf_pwr_if carries the power-gating handshake
// ----------------------------------------------------------
`timescale 1ns/1ns

interface rf_port_if;

    // Write port, takes effect on the edge where we is high
    logic              we;
    rf_pkg::rf_addr_t  waddr;
    rf_pkg::rf_data_t  wdata;

    // Read port, rdata is valid one cycle after re
    logic              re;
    rf_pkg::rf_addr_t  raddr;
    rf_pkg::rf_data_t  rdata;

    // APB slave side issues the accesses
    modport host (output we, waddr, wdata, re, raddr, input rdata);

    // Array wrapper side answers with read data
    modport mem (input we, waddr, wdata, re, raddr, output rdata);

endinterface

interface rf_pwr_if;

    // Outputs from the sequencer
    logic isol_en;
    logic pwr_enable_b_in;
    logic ip_reset;

    // Power acknowledge returned by the array, active low like the enable
    logic pwr_enable_b_out;

    modport ctl (output isol_en, pwr_enable_b_in, ip_reset, input pwr_enable_b_out);

    modport mem (input isol_en, pwr_enable_b_in, ip_reset, output pwr_enable_b_out);

endinterface

/* hw/rf_array_64x14.sv */
// ----------------------------------------------------------
// Behavioral two-port 64x14 register file macro
// Registered read port, output isolation and a delayed
// power-enable acknowledge that models the wake-up time
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "rf_consts.svh"

module rf_array_64x14 (
    input  logic              clk,
    input  logic              reset,
    rf_pwr_if.mem             pwr,
    input  logic              we,
    input  logic              re,
    input  rf_pkg::rf_addr_t  waddr,
    input  rf_pkg::rf_addr_t  raddr,
    input  rf_pkg::rf_data_t  wdata,
    output rf_pkg::rf_data_t  rdata,
    input  logic              access_ok
);

    rf_pkg::rf_data_t              mem [`RF_DEPTH];
    rf_pkg::rf_data_t              rd_q;
    logic [`RF_WAKE_CYCLES-1:0]    wake_dly;
    logic                          mem_on;

    // ------------------------------------------------------------
    // Power acknowledge
    // ------------------------------------------------------------

    // The enable travels through a delay line, the last tap is the ack
    // Reset puts the whole line in the powered-down state
    always_ff @(posedge clk) begin
        if (reset) begin
            wake_dly <= '1;
        end else begin
            wake_dly <= {wake_dly[`RF_WAKE_CYCLES-2:0], pwr.pwr_enable_b_in};
        end
    end

    assign pwr.pwr_enable_b_out = wake_dly[`RF_WAKE_CYCLES-1];

    // Accesses only count once the domain is up and the IP reset is gone
    assign mem_on = !pwr.pwr_enable_b_out && access_ok;

    // ------------------------------------------------------------
    // Storage and read port
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (we && mem_on) begin
            mem[waddr] <= wdata;
        end
        // Read data holds until the next accepted read
        if (re && mem_on) begin
            rd_q <= mem[raddr];
        end
    end

    // Clamp the output low while isolated
    assign rdata = pwr.isol_en ? '0 : rd_q;

endmodule

/* hw/rf_pg_64x14.sv */
// ----------------------------------------------------------
// Power-gated 64x14 register file wrapper
// Stages the IP reset for the array and keeps accesses
// away from it until the staged reset has cleared
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "rf_consts.svh"

module rf_pg_64x14 (
    input  logic      clk,
    input  logic      reset,
    rf_port_if.mem    port,
    rf_pwr_if.mem     pwr
);

    logic [`RF_RST_STAGES-1:0] rst_stage;
    logic                      access_ok;

    // Reset staging chain, shifts the IP reset toward the array
    // A subsystem reset fills it so the array starts out held
    always_ff @(posedge clk) begin
        if (reset) begin
            rst_stage <= '1;
        end else begin
            rst_stage[0] <= pwr.ip_reset;
            for (int i = 1; i < `RF_RST_STAGES; i++) begin
                rst_stage[i] <= rst_stage[i-1];
            end
        end
    end

    // Assertion of the IP reset blocks accesses at once,
    // release waits for the last stage
    assign access_ok = !pwr.ip_reset && !rst_stage[`RF_RST_STAGES-1];

    rf_array_64x14 u_array (
        .clk       (clk),
        .reset     (reset),
        .pwr       (pwr),
        .we        (port.we),
        .re        (port.re),
        .waddr     (port.waddr),
        .raddr     (port.raddr),
        .wdata     (port.wdata),
        .rdata     (port.rdata),
        .access_ok (access_ok)
    );

endmodule

/* hw/rf_power_ctl.sv */
// ----------------------------------------------------------
// Power-gate sequencer
// Orders enable, isolation and IP reset on power-up and
// power-down of the register file domain
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "rf_consts.svh"

module rf_power_ctl (
    input  logic  clk,
    input  logic  reset,
    input  logic  power_req,
    output logic  powered,
    output logic  busy,
    rf_pwr_if.ctl pwr
);

    // Cycles spent in PG_RELEASE, one more than the staging depth
    localparam int unsigned REL_CYCLES = `RF_RST_STAGES + 1;
    localparam int unsigned CNT_W      = $clog2(REL_CYCLES);

    rf_pkg::pg_state_t state;
    logic [CNT_W-1:0]  rel_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= rf_pkg::PG_OFF;
            rel_cnt <= '0;
        end else begin
            case (state)
                rf_pkg::PG_OFF: begin
                    if (power_req) state <= rf_pkg::PG_WAKE;
                end
                // Enable is low, wait for the array to acknowledge
                rf_pkg::PG_WAKE: begin
                    rel_cnt <= '0;
                    if (!pwr.pwr_enable_b_out) state <= rf_pkg::PG_RELEASE;
                end
                // Reset and isolation are released, let the staged reset drain
                rf_pkg::PG_RELEASE: begin
                    rel_cnt <= rel_cnt + 1'b1;
                    if (rel_cnt == CNT_W'(REL_CYCLES - 1)) state <= rf_pkg::PG_ON;
                end
                rf_pkg::PG_ON: begin
                    if (!power_req) state <= rf_pkg::PG_SLEEP;
                end
                // Everything is raised, wait for the acknowledge to follow
                rf_pkg::PG_SLEEP: begin
                    if (pwr.pwr_enable_b_out) state <= rf_pkg::PG_OFF;
                end
                default: state <= rf_pkg::PG_OFF;
            endcase
        end
    end

    // Isolation and IP reset are only off while releasing or on
    assign pwr.isol_en  = (state != rf_pkg::PG_RELEASE) && (state != rf_pkg::PG_ON);
    assign pwr.ip_reset = (state != rf_pkg::PG_RELEASE) && (state != rf_pkg::PG_ON);
    // Enable is active low and drops from PG_WAKE through PG_ON
    assign pwr.pwr_enable_b_in = (state == rf_pkg::PG_OFF) || (state == rf_pkg::PG_SLEEP);

    assign powered = (state == rf_pkg::PG_ON);
    assign busy    = (state == rf_pkg::PG_WAKE) || (state == rf_pkg::PG_RELEASE) ||
                     (state == rf_pkg::PG_SLEEP);

endmodule

/* hw/rf_apb_slave.sv */
// ----------------------------------------------------------
// APB slave of the register file subsystem
// CTRL and STATUS registers plus a window onto the array,
// array reads take one wait state
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "rf_consts.svh"

module rf_apb_slave (
    input  logic              clk,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  rf_pkg::apb_addr_t paddr,
    input  rf_pkg::apb_data_t pwdata,
    output rf_pkg::apb_data_t prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              power_req,
    input  logic              powered,
    input  logic              busy,
    rf_port_if.host           port
);

    // First byte address past the array window
    localparam rf_pkg::apb_addr_t ARR_LIMIT = `RF_ARRAY_BASE + `RF_APB_ADDR_W'(4 * `RF_DEPTH);

    logic              access;
    logic              sel_ctrl;
    logic              sel_status;
    logic              sel_arr;
    logic              arr_ok;
    logic              arr_rd;
    logic              err;
    logic              ctrl_q;
    logic              rd_wait;
    rf_pkg::apb_addr_t arr_off;

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------

    // No transfer is accepted or answered while reset is held
    assign access     = psel && penable && !reset;
    assign sel_ctrl   = (paddr == `RF_REG_CTRL);
    assign sel_status = (paddr == `RF_REG_STATUS);
    // Word-aligned addresses inside the window only
    assign sel_arr    = (paddr >= `RF_ARRAY_BASE) && (paddr < ARR_LIMIT) &&
                        (paddr[1:0] == 2'b00);
    assign arr_off    = paddr - `RF_ARRAY_BASE;

    // Array window is only usable with the domain fully on
    assign arr_ok = sel_arr && powered;
    assign arr_rd = arr_ok && !pwrite;
    assign err    = !(sel_ctrl || sel_status || sel_arr) || (sel_arr && !powered);

    // Array reads finish in the second access cycle, everything else in the first
    assign pready  = access && (!arr_rd || rd_wait);
    assign pslverr = access && err;

    // Marks the wait state of an array read
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_wait <= 1'b0;
        end else begin
            rd_wait <= access && arr_rd && !rd_wait;
        end
    end

    // CTRL bit 0 is the power request and STATUS is read only
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_q <= 1'b0;
        end else if (access && pwrite && sel_ctrl) begin
            ctrl_q <= pwdata[0];
        end
    end

    assign power_req = ctrl_q;

    // ------------------------------------------------------------
    // Array strobes
    // ------------------------------------------------------------
    assign port.we    = access && arr_ok && pwrite;
    assign port.re    = access && arr_rd && !rd_wait;
    assign port.waddr = arr_off[`RF_ADDR_W+1:2];
    assign port.raddr = arr_off[`RF_ADDR_W+1:2];
    // Upper write bits have nowhere to go
    assign port.wdata = pwdata[`RF_WIDTH-1:0];

    // Read data is zero on errors and for writes
    always_comb begin
        prdata = '0;
        if (!err && !pwrite) begin
            if (sel_ctrl) begin
                prdata = {31'b0, ctrl_q};
            end else if (sel_status) begin
                // Bit 1 is busy and bit 0 is powered
                prdata = {30'b0, busy, powered};
            end else begin
                prdata = {{(32 - `RF_WIDTH){1'b0}}, port.rdata};
            end
        end
    end

endmodule

/* hw/rf_subsys_top.sv */
// ----------------------------------------------------------
// Register file subsystem top level
// APB slave, power sequencer and power-gated array,
// joined by the port and power interfaces
// ----------------------------------------------------------
`timescale 1ns/1ns

module rf_subsys_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  rf_pkg::apb_addr_t paddr,
    input  rf_pkg::apb_data_t pwdata,
    output rf_pkg::apb_data_t prdata,
    output logic              pready,
    output logic              pslverr
);

    logic power_req;
    logic powered;
    logic busy;

    rf_port_if port_if ();
    rf_pwr_if  pwr_if ();

    rf_apb_slave u_apb (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .power_req (power_req),
        .powered   (powered),
        .busy      (busy),
        .port      (port_if.host)
    );

    rf_power_ctl u_pwr (
        .clk       (clk),
        .reset     (reset),
        .power_req (power_req),
        .powered   (powered),
        .busy      (busy),
        .pwr       (pwr_if.ctl)
    );

    rf_pg_64x14 u_rf (
        .clk   (clk),
        .reset (reset),
        .port  (port_if.mem),
        .pwr   (pwr_if.mem)
    );

endmodule

/* bench/rf_subsys_props.sv */
// ----------------------------------------------------------
// Register file subsystem protocol checks
// Concurrent assertions on the APB handshake and on the
// isolation of the power-gated array
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "rf_consts.svh"

module rf_subsys_props (
    input logic              clk,
    input logic              reset,
    input logic              psel,
    input logic              penable,
    input logic              pwrite,
    input rf_pkg::apb_addr_t paddr,
    input logic              pready,
    input logic              pslverr,
    input logic              powered,
    input logic              isol_en,
    input logic              pwr_ack_b,
    input rf_pkg::rf_data_t  rdata
);

    // Number of failed assertions, watched by the testbench
    int   err_count = 0;
    logic in_window;

    // Word-aligned address inside the array window
    assign in_window = (paddr >= `RF_ARRAY_BASE) &&
                       (paddr < `RF_ARRAY_BASE + 12'(4 * `RF_DEPTH)) &&
                       (paddr[1:0] == 2'b00);

    // An error response always completes the transfer
    err_needs_ready: assert property (@(posedge clk) disable iff (reset)
        pslverr |-> pready)
        else begin err_count++; $error("pslverr without pready"); end

    // A powered-down array must never be seen without isolation
    ack_isolated: assert property (@(posedge clk) disable iff (reset)
        pwr_ack_b |-> isol_en)
        else begin err_count++; $error("acknowledge high while not isolated"); end

    // Isolation clamps the read data
    rdata_clamped: assert property (@(posedge clk) disable iff (reset)
        isol_en |-> (rdata == '0))
        else begin err_count++; $error("array read data not zero while isolated"); end

    // No response of any kind while reset is held
    quiet_in_reset: assert property (@(posedge clk)
        reset |-> (!pready && !pslverr))
        else begin err_count++; $error("APB response during reset"); end

    // An accepted array read waits exactly one cycle
    read_one_wait: assert property (@(posedge clk) disable iff (reset)
        ($rose(penable) && psel && !pwrite && in_window && powered) |-> !pready ##1 pready)
        else begin err_count++; $error("array read without exactly one wait state"); end

endmodule

/* bench/rf_subsys_tb.sv */
// ----------------------------------------------------------
// Register file subsystem testbench
// Drives the APB port through power-up, random array
// traffic and power-down against a reference array model
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "rf_consts.svh"

module rf_subsys_tb;

    // Traffic and power sequences need about 700 cycles and the rest is margin
    localparam int MAX_CYCLES = 3000;

    logic              clk;
    logic              reset;
    logic              psel;
    logic              penable;
    logic              pwrite;
    rf_pkg::apb_addr_t paddr;
    rf_pkg::apb_data_t pwdata;
    rf_pkg::apb_data_t prdata;
    logic              pready;
    logic              pslverr;

    // Reference array and the entries touched by the random test
    rf_pkg::rf_data_t  model [`RF_DEPTH];
    rf_pkg::rf_addr_t  idx_q [$];
    rf_pkg::rf_addr_t  idx;
    rf_pkg::apb_data_t wdata;
    rf_pkg::apb_data_t status;
    logic              saw_busy;
    integer            seed = 32'hddd8_6214;
    int                cycles;

    rf_subsys_top uut (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    bind rf_subsys_top rf_subsys_props u_props (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pready    (pready),
        .pslverr   (pslverr),
        .powered   (powered),
        .isol_en   (pwr_if.isol_en),
        .pwr_ack_b (pwr_if.pwr_enable_b_out),
        .rdata     (port_if.rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input rf_pkg::apb_data_t exp,
                               input rf_pkg::apb_data_t got);
        assert (got === exp) else
            abort_run($sformatf("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, exp, got));
    endtask

    // Byte address of array entry i
    function automatic rf_pkg::apb_addr_t entry_addr(input rf_pkg::rf_addr_t i);
        return `RF_ARRAY_BASE + {i, 2'b00};
    endfunction

    // Runs one APB transfer and counts the access cycles with pready low
    task automatic apb_xfer(input rf_pkg::apb_addr_t addr, input logic write,
                            input rf_pkg::apb_data_t wd, output rf_pkg::apb_data_t rd,
                            output logic err, output int waits);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wd;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waits   = 0;
        // Outputs are looked at mid-cycle where they have settled
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        rd  = prdata;
        err = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic do_access(input string name, input rf_pkg::apb_addr_t addr, input logic write,
                             input rf_pkg::apb_data_t wd, input rf_pkg::apb_data_t exp_rd,
                             input logic exp_err, input int exp_waits);
        rf_pkg::apb_data_t rd;
        logic              err;
        int                waits;
        apb_xfer(addr, write, wd, rd, err, waits);
        if (!write) check_value({name, " data"}, exp_rd, rd);
        check_value({name, " pslverr"}, {31'b0, exp_err}, {31'b0, err});
        check_value({name, " wait states"}, 32'(exp_waits), 32'(waits));
    endtask

    // Reads STATUS until it equals target or 20 reads have been made
    task automatic poll_status(input rf_pkg::apb_data_t target, output rf_pkg::apb_data_t last,
                               output logic busy_seen);
        rf_pkg::apb_data_t rd;
        logic              err;
        int                waits;
        busy_seen = 1'b0;
        last      = '1;
        for (int i = 0; i < 20; i++) begin
            apb_xfer(`RF_REG_STATUS, 1'b0, 32'h0, rd, err, waits);
            last = rd;
            if (rd[1]) busy_seen = 1'b1;
            if (rd == target) break;
        end
    endtask

    // ------------------------------------------------------------
    // Cycle limit and watch on the concurrent assertions
    // ------------------------------------------------------------
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (uut.u_props.err_count != 0) abort_run("a protocol assertion failed");
            if (cycles >= MAX_CYCLES) abort_run("timeout, the tests did not finish in time");
        end
    end

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------
    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        reset   = 1'b1;

        // A CTRL write issued during reset must neither complete nor take effect
        repeat (2) @(posedge clk);
        #1;
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = `RF_REG_CTRL;
        pwdata = 32'h1;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        #1;
        reset   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;

        // Domain is off after reset, so the array window answers with errors
        do_access("reset status", `RF_REG_STATUS, 1'b0, 32'h0, 32'h0, 1'b0, 0);
        do_access("reset ctrl", `RF_REG_CTRL, 1'b0, 32'h0, 32'h0, 1'b0, 0);
        do_access("read while off", entry_addr(6'd5), 1'b0, 32'h0, 32'h0, 1'b1, 0);
        do_access("write while off", entry_addr(6'd5), 1'b1, 32'h3fff, 32'h0, 1'b1, 0);

        // Power-up passes through busy before powered shows
        do_access("power request", `RF_REG_CTRL, 1'b1, 32'h1, 32'h0, 1'b0, 0);
        do_access("ctrl readback", `RF_REG_CTRL, 1'b0, 32'h0, 32'h1, 1'b0, 0);
        poll_status(32'h1, status, saw_busy);
        check_value("power up busy", 32'h1, {31'b0, saw_busy});
        check_value("power up status", 32'h1, status);

        // The upper 18 bits of each random write word are dropped by the slave
        for (int n = 0; n < 64; n++) begin
            idx        = rf_pkg::rf_addr_t'($random(seed));
            wdata      = $random(seed);
            model[idx] = wdata[`RF_WIDTH-1:0];
            idx_q.push_back(idx);
            do_access("array write", entry_addr(idx), 1'b1, wdata, 32'h0, 1'b0, 0);
        end
        // Every entry reads back zero-extended with one wait state
        foreach (idx_q[n]) begin
            do_access($sformatf("array read %0d", idx_q[n]), entry_addr(idx_q[n]), 1'b0, 32'h0,
                      {{(32 - `RF_WIDTH){1'b0}}, model[idx_q[n]]}, 1'b0, 1);
        end

        // Unmapped and misaligned addresses
        do_access("unmapped read", 12'h008, 1'b0, 32'h0, 32'h0, 1'b1, 0);
        do_access("unmapped write", 12'h00c, 1'b1, 32'h1, 32'h0, 1'b1, 0);
        do_access("misaligned read", 12'h102, 1'b0, 32'h0, 32'h0, 1'b1, 0);

        // Power-down brings the error responses back
        do_access("power release", `RF_REG_CTRL, 1'b1, 32'h0, 32'h0, 1'b0, 0);
        poll_status(32'h0, status, saw_busy);
        check_value("power down status", 32'h0, status);
        do_access("read after off", entry_addr(idx_q[0]), 1'b0, 32'h0, 32'h0, 1'b1, 0);
        do_access("write after off", entry_addr(idx_q[0]), 1'b1, 32'h1, 32'h0, 1'b1, 0);

        repeat (2) @(posedge clk);
        if (uut.u_props.err_count != 0) begin
            abort_run("a protocol assertion failed");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

/* vlog.f */
+incdir+hw
hw/rf_pkg.sv
hw/rf_ifs.sv
hw/rf_array_64x14.sv
hw/rf_pg_64x14.sv
hw/rf_power_ctl.sv
hw/rf_apb_slave.sv
hw/rf_subsys_top.sv
bench/rf_subsys_props.sv
bench/rf_subsys_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := rf_subsys_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
PASS_MSG := Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
